// File: motoro3_cfg.svh
`ifndef MOTORO3_CFG_SVH
`define MOTORO3_CFG_SVH

// width of the pwm period and minimum pulse fields
`define PWM_LEN_W 12

// width of on-time, carry and accounting values
`define POS_W 16

// width of the step length and the step cycle counter
`define STEP_LEN_W 16

// electrical steps per commutation cycle
`define STEP_COUNT 6

// period after reset, in clocks
`define PWM_LEN_RST 12'd400

// step length after reset, in clocks
`define STEP_LEN_RST 16'd4000

`endif

// File: motoro3Pkg.sv
`default_nettype none
`include "motoro3_cfg.svh"

package motoro3Pkg;

    // register word at address 0
    typedef struct packed {
        logic [`PWM_LEN_W-1:0] pwmLenWant;
        logic [`PWM_LEN_W-1:0] pwmMinMask;
        logic [7:0]            reserved;
    } cfgTimingT;

    // register word at address 1
    typedef struct packed {
        logic [`POS_W-1:0]      pwmLenPos;
        logic [`STEP_LEN_W-1:0] stepLen;
    } cfgDriveT;

    // one data word, decoded by address
    typedef union packed {
        cfgTimingT timing;
        cfgDriveT  drive;
    } regWordU;

    // host write request, address 2 bit 0 is run
    typedef struct packed {
        logic [1:0] addr;
        regWordU    data;
    } regReqT;

    // step boundary pulses and the electrical step index
    typedef struct packed {
        logic       first;
        logic       last;
        logic [2:0] sgStep;
    } stepTickT;

    // power stage gate drives
    typedef struct packed {
        logic hiA;
        logic hiB;
        logic hiC;
        logic loA;
        logic loB;
        logic loC;
    } gateT;

    // per-step shortfall, lost is wanted minus real
    typedef struct packed {
        logic              valid;
        logic [2:0]        step;
        logic [`POS_W-1:0] lost;
    } stepReportT;

endpackage

`default_nettype wire

// File: motoro3RegPort.sv
`timescale 1ns/1ns
`default_nettype none
`include "motoro3_cfg.svh"

module motoro3RegPort (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  req,
    output logic                  ack,
    input  motoro3Pkg::regReqT    regReq,
    output motoro3Pkg::cfgTimingT timing,
    output motoro3Pkg::cfgDriveT  drive,
    output logic                  run
);

    // write strobe on the sample where req is first seen high
    logic wrEn;

    // ack low means idle, so req high here is a fresh request
    assign wrEn = req && !ack;

    // two-state acknowledge machine
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
        end else begin
            case (ack)
                // idle, wait for req
                1'b0: if (req) ack <= 1'b1;
                // acked, wait for req to drop
                1'b1: if (!req) ack <= 1'b0;
            endcase
        end
    end

    // configuration registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timing.pwmLenWant <= `PWM_LEN_RST;
            timing.pwmMinMask <= '0;
            timing.reserved   <= '0;
            drive.pwmLenPos   <= '0;
            drive.stepLen     <= `STEP_LEN_RST;
            run               <= 1'b0;
        end else if (wrEn) begin
            // same word, read as timing or drive by address
            case (regReq.addr)
                2'd0: timing <= regReq.data.timing;
                2'd1: drive <= regReq.data.drive;
                2'd2: run <= regReq.data[0];
                default: ;
            endcase
        end
    end

    // ack only answers a request seen on the edge before
    ackAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// File: motoro3StepTimer.sv
`timescale 1ns/1ns
`default_nettype none
`include "motoro3_cfg.svh"

module motoro3StepTimer (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  logic [`STEP_LEN_W-1:0] stepLen,
    output motoro3Pkg::stepTickT   stepTick
);

    // clock index inside the current step, 0 in the first cycle
    logic [`STEP_LEN_W-1:0] cnt;
    logic [`STEP_LEN_W-1:0] cntNext;
    // step index after the current one, modulo six
    logic [2:0]             stepNext;
    // set once the first step after run has opened
    logic                   active;
    // a new step opens on the next edge
    logic                   stepOpen;

    // new step after last, or right after run came up
    assign stepOpen = !active || stepTick.last;

    always_comb begin
        if (stepOpen) begin
            cntNext = '0;
        end else begin
            cntNext = cnt + 1'b1;
        end
        // wrap after the sixth step
        if (stepTick.sgStep == 3'(`STEP_COUNT - 1)) begin
            stepNext = '0;
        end else begin
            stepNext = stepTick.sgStep + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt      <= '0;
            active   <= 1'b0;
            stepTick <= '0;
        end else if (!run) begin
            // stopped, hold everything at the start position
            cnt      <= '0;
            active   <= 1'b0;
            stepTick <= '0;
        end else begin
            active         <= 1'b1;
            cnt            <= cntNext;
            stepTick.first <= stepOpen;
            // >= so a shortened stepLen still ends the step
            stepTick.last  <= (cntNext >= stepLen - 1'b1);
            // index moves together with first
            if (active && stepTick.last) begin
                stepTick.sgStep <= stepNext;
            end
        end
    end

    // a step of one clock is the only case where both pulses meet
    firstLastApart: assert property (@(posedge clk) disable iff (!arstN)
        (stepTick.first && stepTick.last) |-> ($past(stepLen) == 1));

endmodule

`default_nettype wire

// File: motoro3PwmGenerator.sv
`timescale 1ns/1ns
`default_nettype none
`include "motoro3_cfg.svh"

module motoro3PwmGenerator (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    run,
    input  motoro3Pkg::stepTickT    stepTick,
    input  motoro3Pkg::cfgTimingT   timing,
    input  motoro3Pkg::cfgDriveT    drive,
    output motoro3Pkg::gateT        gate,
    output logic                    pwm,
    output motoro3Pkg::stepReportT  report
);

    // clock index in the current period and its latched length
    logic [`PWM_LEN_W-1:0] perCnt;
    logic [`PWM_LEN_W-1:0] perLen;
    logic                  periodStart;
    // carry, sum and the minimum pulse test
    logic [`POS_W-1:0]     remain;
    logic [`POS_W-1:0]     sum;
    logic [`POS_W-1:0]     minExt;
    logic [`POS_W-1:0]     capLen;
    logic [`POS_W-1:0]     pulseLen;
    logic                  passMin;
    // clocks of pulse still to emit
    logic [`POS_W-1:0]     onCnt;
    // wanted and real on-time of the running step
    logic [`POS_W-1:0]     wantAcc;
    logic [`POS_W-1:0]     realAcc;
    logic [`POS_W-1:0]     realNow;
    // report fields
    logic                  repValid;
    logic [2:0]            repStep;
    logic [`POS_W-1:0]     repLost;

    // period opens on first and whenever the latched length runs out
    assign periodStart = run && (stepTick.first || perCnt >= perLen);

    assign sum     = remain + drive.pwmLenPos;
    assign minExt  = `POS_W'(timing.pwmMinMask);
    // longest pulse leaves one low clock per period
    assign capLen  = `POS_W'(timing.pwmLenWant) - 1'b1;
    assign passMin = (sum >= minExt);
    assign pulseLen = (sum > capLen) ? capLen : sum;

    // the last clock of a step still counts as real on-time
    assign realNow = realAcc + `POS_W'(pwm);

    assign pwm = run && (onCnt != '0);

    // period counter, length sampled at each start
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            perCnt <= '0;
            perLen <= `PWM_LEN_RST;
        end else if (!run) begin
            perCnt <= '0;
            perLen <= timing.pwmLenWant;
        end else if (periodStart) begin
            perCnt <= `PWM_LEN_W'(1);
            perLen <= timing.pwmLenWant;
        end else begin
            perCnt <= perCnt + 1'b1;
        end
    end

    // carry too-short on-time, drop it at the step end
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remain <= '0;
            onCnt  <= '0;
        end else if (!run) begin
            remain <= '0;
            onCnt  <= '0;
        end else begin
            if (stepTick.last) begin
                remain <= '0;
            end else if (periodStart) begin
                remain <= passMin ? '0 : sum;
            end
            // pulse begins on the clock after the start
            if (periodStart && passMin) begin
                onCnt <= pulseLen;
            end else if (onCnt != '0) begin
                onCnt <= onCnt - 1'b1;
            end
        end
    end

    // wanted versus real accounting
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantAcc  <= '0;
            realAcc  <= '0;
            repValid <= 1'b0;
        end else begin
            repValid <= run && stepTick.last;
            if (!run || stepTick.last) begin
                wantAcc <= '0;
                realAcc <= '0;
            end else begin
                if (periodStart) wantAcc <= wantAcc + drive.pwmLenPos;
                if (pwm) realAcc <= realNow;
            end
        end
    end

    // step and shortfall, only meaningful with valid
    always_ff @(posedge clk) begin
        if (stepTick.last) begin
            repStep <= stepTick.sgStep;
            repLost <= wantAcc - realNow;
        end
    end

    assign report = '{valid: repValid, step: repStep, lost: repLost};

    // six-step table, pwm on one high side and one low side held on
    always_comb begin
        gate = '0;
        if (run) begin
            case (stepTick.sgStep)
                3'd0: begin gate.hiA = pwm; gate.loB = 1'b1; end
                3'd1: begin gate.hiA = pwm; gate.loC = 1'b1; end
                3'd2: begin gate.hiB = pwm; gate.loC = 1'b1; end
                3'd3: begin gate.hiB = pwm; gate.loA = 1'b1; end
                3'd4: begin gate.hiC = pwm; gate.loA = 1'b1; end
                3'd5: begin gate.hiC = pwm; gate.loB = 1'b1; end
                default: gate = '0;
            endcase
        end
    end

    // a running pulse always fits inside the latched period
    onCntCapped: assert property (@(posedge clk) disable iff (!arstN)
        (onCnt != '0) |-> (onCnt < `POS_W'(perLen)));

endmodule

`default_nettype wire

// File: motoro3Top.sv
`timescale 1ns/1ns
`default_nettype none

module motoro3Top (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   req,
    output logic                   ack,
    input  motoro3Pkg::regReqT     regReq,
    output motoro3Pkg::gateT       gate,
    output logic                   pwm,
    output motoro3Pkg::stepReportT report
);

    // configuration from the register port
    motoro3Pkg::cfgTimingT timing;
    motoro3Pkg::cfgDriveT  drive;
    logic                  run;
    // step boundaries to the generator
    motoro3Pkg::stepTickT  stepTick;

    motoro3RegPort uRegPort (
        .clk    (clk),
        .arstN  (arstN),
        .req    (req),
        .ack    (ack),
        .regReq (regReq),
        .timing (timing),
        .drive  (drive),
        .run    (run)
    );

    // step length comes from the drive word
    motoro3StepTimer uStepTimer (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .stepLen  (drive.stepLen),
        .stepTick (stepTick)
    );

    motoro3PwmGenerator uPwmGenerator (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .stepTick (stepTick),
        .timing   (timing),
        .drive    (drive),
        .gate     (gate),
        .pwm      (pwm),
        .report   (report)
    );

endmodule

`default_nettype wire

// File: motoro3TopTb.sv
`timescale 1ns/1ns
`default_nettype none

module motoro3TopTb;

    localparam int CLK_PERIOD = 40;
    localparam int SEED = 77697;

    // per case: period, minimum pulse, on-time, step length, steps to run
    localparam int HS_LEN = 50;
    localparam int HS_POS = 17;
    localparam int HS_STEP = 100;
    localparam int HS_STEPS = 3;
    localparam int NP_LEN = 64;
    localparam int NP_POS = 40;
    localparam int NP_STEP = 256;
    localparam int NP_STEPS = 4;
    localparam int MC_LEN = 200;
    localparam int MC_MASK = 100;
    localparam int MC_POS = 30;
    localparam int MC_STEP = 1200;
    localparam int MC_STEPS = 3;
    localparam int SF_LEN = 80;
    localparam int SF_POS = 100;
    localparam int SF_STEP = 320;
    localparam int SF_STEPS = 3;
    // commutation uses random multiples of the period
    localparam int CM_LEN = 40;
    localparam int CM_POS = 10;
    localparam int CM_MAX_PERIODS = 5;
    localparam int CM_STEPS = 9;

    localparam int RUN_CLK = HS_STEPS * HS_STEP + NP_STEPS * NP_STEP + MC_STEPS * MC_STEP
        + SF_STEPS * SF_STEP + (CM_STEPS + 1) * CM_MAX_PERIODS * CM_LEN;
    localparam int MARGIN_CLK = 2000;

    logic                   clk;
    logic                   arstN;
    logic                   req;
    logic                   ack;
    motoro3Pkg::regReqT     regReq;
    motoro3Pkg::gateT       gate;
    logic                   pwm;
    motoro3Pkg::stepReportT report;

    // checker state, set by the stimulus
    string       testName;
    logic        runCheck;
    logic        idleCheck;
    logic [15:0] pulseExp;
    logic [15:0] lostExp;
    // scoreboard of the running step and the current pulse
    logic [2:0]  stepNow;
    logic [2:0]  stepShown;
    logic [2:0]  hiSide;
    logic [2:0]  loSide;
    motoro3Pkg::gateT gateExp;
    logic [15:0] hiRun;
    logic        pwmLast;
    int          errCount;
    int          pulseSeen;
    int          reportSeen;
    int unsigned seedDummy;

    motoro3Top DUT (
        .clk    (clk),
        .arstN  (arstN),
        .req    (req),
        .ack    (ack),
        .regReq (regReq),
        .gate   (gate),
        .pwm    (pwm),
        .report (report)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // first pulse of a step, on-time piles up until it reaches the minimum pulse
    function automatic int pulseFor(input int len, input int mask, input int pos);
        int sum;
        sum = 0;
        do sum += pos; while (sum < mask);
        return (sum > len - 1) ? len - 1 : sum;
    endfunction

    // wanted minus real over one step of whole periods
    function automatic int lostPerStep(input int len, input int mask, input int pos,
                                       input int periods);
        int remain;
        int wanted;
        int realHi;
        int sum;
        remain = 0;
        wanted = 0;
        realHi = 0;
        for (int i = 0; i < periods; i++) begin
            sum = remain + pos;
            wanted += pos;
            if (sum >= mask) begin
                realHi += (sum > len - 1) ? len - 1 : sum;
                remain = 0;
            end else begin
                remain = sum;
            end
        end
        return wanted - realHi;
    endfunction

    // six-step table, high side follows step/2, low side from the list
    always_comb begin
        stepShown = stepNow;
        // in the report cycle the DUT is already in the next step
        if (report.valid) begin
            stepShown = (stepNow == 3'd5) ? 3'd0 : stepNow + 3'd1;
        end
        hiSide = pwm ? (3'b100 >> (stepShown >> 1)) : 3'b000;
        case (stepShown)
            3'd0: loSide = 3'b010;
            3'd1: loSide = 3'b001;
            3'd2: loSide = 3'b001;
            3'd3: loSide = 3'b100;
            3'd4: loSide = 3'b100;
            default: loSide = 3'b010;
        endcase
        gateExp = {hiSide, loSide};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stepNow    <= '0;
            hiRun      <= '0;
            pwmLast    <= 1'b0;
            pulseSeen  <= 0;
            reportSeen <= 0;
        end else begin
            pwmLast <= pwm;
            hiRun   <= pwm ? hiRun + 16'd1 : 16'd0;
            if (!runCheck) begin
                stepNow <= '0;
            end else if (report.valid) begin
                stepNow    <= (stepNow == 3'd5) ? 3'd0 : stepNow + 3'd1;
                reportSeen <= reportSeen + 1;
            end
            if (runCheck && pwmLast && !pwm) pulseSeen <= pulseSeen + 1;
        end
    end

    ackRise: assert property (@(posedge clk) disable iff (!arstN) $rose(ack) |-> $past(req))
        else begin
            errCount++;
            $display("handshake error in %s: ack rose without a request", testName);
        end

    ackFall: assert property (@(posedge clk) disable iff (!arstN) $fell(ack) |-> !$past(req))
        else begin
            errCount++;
            $display("handshake error in %s: ack dropped while req was high", testName);
        end

    pulseLen: assert property (@(posedge clk) disable iff (!arstN)
        (runCheck && $fell(pwm)) |-> (hiRun == pulseExp))
        else begin
            errCount++;
            $display("[FAIL] %s: pulse length expected %0d actual %0d",
                testName, $sampled(pulseExp), $sampled(hiRun));
        end

    reportStep: assert property (@(posedge clk) disable iff (!arstN)
        (runCheck && report.valid) |-> (report.step == stepNow))
        else begin
            errCount++;
            $display("[FAIL] %s: report step expected %0d actual %0d",
                testName, $sampled(stepNow), $sampled(report.step));
        end

    reportLost: assert property (@(posedge clk) disable iff (!arstN)
        (runCheck && report.valid) |-> (report.lost == lostExp))
        else begin
            errCount++;
            $display("[FAIL] %s: report lost expected %0d actual %0d",
                testName, $sampled(lostExp), $sampled(report.lost));
        end

    gateTable: assert property (@(posedge clk) disable iff (!arstN) runCheck |-> (gate == gateExp))
        else begin
            errCount++;
            $display("[FAIL] %s: gate expected %b actual %b",
                testName, $sampled(gateExp), $sampled(gate));
        end

    gateIdle: assert property (@(posedge clk) disable iff (!arstN)
        idleCheck |-> (gate == '0 && !pwm && !report.valid))
        else begin
            errCount++;
            $display("[FAIL] %s: idle outputs expected 0 actual gate %b pwm %b valid %b",
                testName, $sampled(gate), $sampled(pwm), $sampled(report.valid));
        end

    // four-phase write, returns once ack is low again
    task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        regReq.addr <= addr;
        regReq.data <= data;
        req         <= 1'b1;
        do @(posedge clk); while (ack !== 1'b1);
        req <= 1'b0;
        do @(posedge clk); while (ack !== 1'b0);
    endtask

    task automatic setTiming(input int len, input int mask);
        motoro3Pkg::cfgTimingT t;
        t.pwmLenWant = 12'(len);
        t.pwmMinMask = 12'(mask);
        t.reserved   = '0;
        writeReg(2'd0, t);
    endtask

    task automatic setDrive(input int pos, input int stepLen);
        motoro3Pkg::cfgDriveT d;
        d.pwmLenPos = 16'(pos);
        d.stepLen   = 16'(stepLen);
        writeReg(2'd1, d);
    endtask

    task automatic startRun();
        idleCheck <= 1'b0;
        writeReg(2'd2, 32'd1);
        runCheck <= 1'b1;
    endtask

    task automatic stopRun();
        runCheck <= 1'b0;
        writeReg(2'd2, 32'd0);
        idleCheck <= 1'b1;
    endtask

    // count step reports seen on the edge
    task automatic waitReports(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (report.valid === 1'b1) seen++;
        end
    endtask

    task automatic runCase(input string name, input int len, input int mask, input int pos,
                           input int stepLen, input int steps);
        testName = name;
        pulseExp = 16'(pulseFor(len, mask, pos));
        lostExp  = 16'(lostPerStep(len, mask, pos, stepLen / len));
        setTiming(len, mask);
        setDrive(pos, stepLen);
        startRun();
        waitReports(steps);
        stopRun();
    endtask

    // watchdog
    initial begin
        repeat (RUN_CLK + MARGIN_CLK) @(posedge clk);
        $display("watchdog expired after %0d clocks, test %s did not finish",
            RUN_CLK + MARGIN_CLK, testName);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seedDummy = $urandom(SEED);
        req       = 1'b0;
        regReq    = '0;
        arstN     = 1'b0;
        runCheck  = 1'b0;
        idleCheck = 1'b0;
        pulseExp  = '0;
        lostExp   = '0;
        errCount  = 0;
        testName  = "reset";
        repeat (3) @(posedge clk);
        arstN     <= 1'b1;
        idleCheck <= 1'b1;
        repeat (4) @(posedge clk);

        runCase("handshake", HS_LEN, 0, HS_POS, HS_STEP, HS_STEPS);
        runCase("normalPwm", NP_LEN, 0, NP_POS, NP_STEP, NP_STEPS);
        runCase("minPulseCarry", MC_LEN, MC_MASK, MC_POS, MC_STEP, MC_STEPS);
        runCase("shortfall", SF_LEN, 0, SF_POS, SF_STEP, SF_STEPS);

        // step length changes early in each step, so periods stay aligned
        testName = "commutation";
        pulseExp = 16'(pulseFor(CM_LEN, 0, CM_POS));
        lostExp  = 16'(lostPerStep(CM_LEN, 0, CM_POS, 1));
        setTiming(CM_LEN, 0);
        setDrive(CM_POS, CM_LEN * (1 + int'($urandom % CM_MAX_PERIODS)));
        startRun();
        repeat (CM_STEPS) begin
            waitReports(1);
            setDrive(CM_POS, CM_LEN * (1 + int'($urandom % CM_MAX_PERIODS)));
        end
        stopRun();
        repeat (4) @(posedge clk);

        $display("summary: %0d pulses and %0d reports checked, %0d errors",
            pulseSeen, reportSeen, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: motoro3Top.f
+incdir+.
motoro3Pkg.sv
motoro3RegPort.sv
motoro3StepTimer.sv
motoro3PwmGenerator.sv
motoro3Top.sv
motoro3TopTb.sv

// File: Makefile
# Verilator build and run for the motor drive testbench

VERILATOR ?= verilator
TOP       ?= motoro3TopTb
FILELIST  ?= motoro3Top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
